// ==== m_ext_unit.f ====
+incdir+verification
common/m_ext_pkg.sv
src/m_ext/m_ext_decode.sv
src/m_ext/m_ext_delay.sv
src/m_ext/m_ext_compute.sv
src/m_ext_unit.sv
verification/m_ext_unit_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = m_ext_unit_tb
FILELIST = m_ext_unit.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/m_ext_ref.svh ====
`ifndef M_EXT_REF_SVH
`define M_EXT_REF_SVH

function automatic logic [m_ext_pkg::WORD_W-1:0] m_ext_ref(
    input m_ext_pkg::m_ext_opcode_e        op,
    input logic [m_ext_pkg::WORD_W-1:0]    a,
    input logic [m_ext_pkg::WORD_W-1:0]    b
);
    localparam int W = m_ext_pkg::WORD_W;
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic [2*W-1:0]        ua;
    logic [2*W-1:0]        ub;
    logic [2*W-1:0]        p;
    logic                  ovf;

    sa  = {{W{a[W-1]}}, a};
    sb  = {{W{b[W-1]}}, b};
    ua  = {{W{1'b0}}, a};
    ub  = {{W{1'b0}}, b};
    ovf = (a == {1'b1, {(W-1){1'b0}}}) && (&b);
    p   = '0;
    case (op)
        m_ext_pkg::MUL:    p = sa * sb;
        m_ext_pkg::MULH:   p = (sa * sb) >> W;
        m_ext_pkg::MULHSU: p = (sa * $signed(ub)) >> W;
        m_ext_pkg::MULHU:  p = (ua * ub) >> W;
        m_ext_pkg::DIV: begin
            if (b == '0)
                p = '1;
            else if (ovf)
                p = ua;
            else
                p = sa / sb; // truncates toward zero.
        end
        m_ext_pkg::DIVU:   p = (b == '0) ? '1 : ua / ub;
        m_ext_pkg::REM: begin
            if (b == '0)
                p = ua;
            else if (ovf)
                p = '0;
            else
                p = sa % sb;
        end
        m_ext_pkg::REMU:   p = (b == '0) ? ua : ua % ub;
        default:           p = '0;
    endcase
    return p[W-1:0];
endfunction

`endif

// ==== verification/m_ext_unit_tb.sv ====
`timescale 1ns/1ps

module m_ext_unit_tb;

    localparam int W  = m_ext_pkg::WORD_W;
    localparam int AW = m_ext_pkg::REG_ADDR_W;

    localparam int N_MUL_DIR  = 8;
    localparam int N_MUL_RAND = 40;
    localparam int N_DIV_RAND = 40;
    localparam int N_CORNER   = 8;
    localparam int PIPE_SLOTS = 32;
    localparam int WE_SLOTS   = 3;
    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT_CYCLES = N_MUL_DIR + N_MUL_RAND + N_DIV_RAND + N_CORNER
                                  + PIPE_SLOTS + WE_SLOTS + m_ext_pkg::M_EXT_LATENCY
                                  + 20 * NUM_TESTS;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     valid_i;
    m_ext_pkg::m_ext_opcode_e opcode_i;
    logic                     rf_we_i;
    logic [AW-1:0]            rf_waddr_i;
    logic [W-1:0]             src_a_i;
    logic [W-1:0]             src_b_i;
    logic                     valid_m3_o;
    logic                     valid_o;
    logic                     rf_we_o;
    logic [AW-1:0]            rf_waddr_o;
    logic [W-1:0]             rf_wdata_o;

    int    seed;
    int    cycle;
    int    checks;
    int    errors;
    int    tests_run;
    int    test_err_start;
    string cur_test;

    logic [W-1:0]  exp_data_q [$];
    logic [AW-1:0] exp_addr_q [$];
    logic          exp_we_q   [$];
    bit            issued_at  [0:TIMEOUT_CYCLES+8]; // edge at which an op was issued.

    `include "m_ext_ref.svh"

    m_ext_unit #(
        .WORD_W     (W),
        .REG_ADDR_W (AW)
    ) i_m_ext_unit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .opcode_i   (opcode_i),
        .rf_we_i    (rf_we_i),
        .rf_waddr_i (rf_waddr_i),
        .src_a_i    (src_a_i),
        .src_b_i    (src_b_i),
        .valid_m3_o (valid_m3_o),
        .valid_o    (valid_o),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: results did not drain within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end else begin
            cycle <= cycle + 1;
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
                     cur_test, what, expected, actual);
        end
    endtask

    // outputs settle between edges, so compare on the falling edge.
    always @(negedge clk_i) begin : compare_proc
        if (cycle >= 3)
            check_value("valid_m3_o", 64'(issued_at[cycle-3]), 64'(valid_m3_o));
        else
            check_value("valid_m3_o", 64'(0), 64'(valid_m3_o));
        if (cycle >= 5)
            check_value("valid_o", 64'(issued_at[cycle-5]), 64'(valid_o));
        else
            check_value("valid_o", 64'(0), 64'(valid_o));

        if (valid_o === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("ERROR: test %s saw a result with no operation in flight", cur_test);
            end else begin
                check_value("rf_wdata_o", 64'(exp_data_q.pop_front()), 64'(rf_wdata_o));
                check_value("rf_waddr_o", 64'(exp_addr_q.pop_front()), 64'(rf_waddr_o));
                check_value("rf_we_o", 64'(exp_we_q.pop_front()), 64'(rf_we_o));
            end
        end else begin
            check_value("rf_we_o idle", 64'(0), 64'(rf_we_o));
        end

        // the op on the inputs now was issued at the last edge.
        if (valid_i && rst_n_i) begin
            exp_data_q.push_back(m_ext_ref(opcode_i, src_a_i, src_b_i));
            exp_addr_q.push_back(rf_waddr_i);
            exp_we_q.push_back(rf_we_i);
            issued_at[cycle] = 1'b1;
        end
    end

    task automatic issue_op(input m_ext_pkg::m_ext_opcode_e op, input logic [W-1:0] a,
                            input logic [W-1:0] b, input logic we, input logic [AW-1:0] addr);
        @(posedge clk_i);
        valid_i    <= 1'b1;
        opcode_i   <= op;
        src_a_i    <= a;
        src_b_i    <= b;
        rf_we_i    <= we;
        rf_waddr_i <= addr;
    endtask

    task automatic idle_cycle;
        @(posedge clk_i);
        valid_i <= 1'b0;
        rf_we_i <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic finish_test;
        int drain;
        drain = 0;
        idle_cycle();
        @(posedge clk_i);
        while (exp_data_q.size() != 0 && drain < m_ext_pkg::M_EXT_LATENCY + 2) begin
            @(posedge clk_i);
            drain++;
        end
        repeat (2) @(posedge clk_i);
        tests_run++;
        $display("test %-10s done, %0d errors", cur_test, errors - test_err_start);
    endtask

    initial begin : main_proc
        logic [31:0]  rnd;
        logic [W-1:0] a;
        logic [W-1:0] b;

        seed       = 342;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        opcode_i   = m_ext_pkg::MUL;
        rf_we_i    = 1'b0;
        rf_waddr_i = '0;
        src_a_i    = '0;
        src_b_i    = '0;

        start_test("reset");
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        finish_test();

        start_test("multiply");
        issue_op(m_ext_pkg::MUL,    32'd7,        32'hffff_fffd, 1'b1, 5'd1);
        issue_op(m_ext_pkg::MULH,   32'h8000_0000, 32'h8000_0000, 1'b1, 5'd2);
        issue_op(m_ext_pkg::MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 5'd3);
        issue_op(m_ext_pkg::MULHU,  32'hffff_ffff, 32'hffff_ffff, 1'b1, 5'd4);
        issue_op(m_ext_pkg::MUL,    32'h1234_5678, 32'h9abc_def0, 1'b1, 5'd5);
        issue_op(m_ext_pkg::MULH,   32'hffff_fffb, 32'd3,         1'b1, 5'd6);
        issue_op(m_ext_pkg::MULHSU, 32'h8000_0000, 32'd2,         1'b1, 5'd7);
        issue_op(m_ext_pkg::MULHU,  32'd0,         32'h1234,      1'b1, 5'd8);
        for (int i = 0; i < N_MUL_RAND; i++) begin
            rnd = $random(seed);
            issue_op(m_ext_pkg::m_ext_opcode_e'({1'b0, rnd[1:0]}), $random(seed),
                     $random(seed), 1'b1, rnd[AW+3:4]);
        end
        finish_test();

        start_test("divide");
        for (int i = 0; i < N_DIV_RAND; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = rnd[2] ? $random(seed) : $random(seed) >>> 24; // small divisors too.
            issue_op(m_ext_pkg::m_ext_opcode_e'({1'b1, rnd[1:0]}), a, b, 1'b1, rnd[AW+3:4]);
        end
        finish_test();

        start_test("corner");
        issue_op(m_ext_pkg::DIV,  32'h1234_5678, 32'd0,         1'b1, 5'd10);
        issue_op(m_ext_pkg::DIVU, 32'h8765_4321, 32'd0,         1'b1, 5'd11);
        issue_op(m_ext_pkg::REM,  32'hdead_beef, 32'd0,         1'b1, 5'd12);
        issue_op(m_ext_pkg::REMU, 32'h0bad_f00d, 32'd0,         1'b1, 5'd13);
        issue_op(m_ext_pkg::DIV,  32'h8000_0000, 32'hffff_ffff, 1'b1, 5'd14);
        issue_op(m_ext_pkg::REM,  32'h8000_0000, 32'hffff_ffff, 1'b1, 5'd15);
        issue_op(m_ext_pkg::DIVU, 32'h8000_0000, 32'hffff_ffff, 1'b1, 5'd16);
        issue_op(m_ext_pkg::REMU, 32'h8000_0000, 32'hffff_ffff, 1'b1, 5'd17);
        finish_test();

        start_test("pipeline");
        for (int i = 0; i < PIPE_SLOTS; i++) begin
            rnd = $random(seed);
            if (rnd[3] || rnd[4])
                issue_op(m_ext_pkg::m_ext_opcode_e'(rnd[2:0]), $random(seed),
                         $random(seed), rnd[5], AW'(i));
            else
                idle_cycle();
        end
        finish_test();

        start_test("write_en");
        issue_op(m_ext_pkg::MUL, 32'd6, 32'd9, 1'b0, 5'd20); // result without a write.
        idle_cycle();
        issue_op(m_ext_pkg::MULHU, 32'hffff_0000, 32'h0001_0000, 1'b1, 5'd21);
        finish_test();

        if (exp_data_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d results were never produced", exp_data_q.size());
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src/m_ext_unit.sv ====
`timescale 1ns/1ps

module m_ext_unit #(
    parameter int WORD_W     = m_ext_pkg::WORD_W,
    parameter int REG_ADDR_W = m_ext_pkg::REG_ADDR_W
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      valid_i,
    input  m_ext_pkg::m_ext_opcode_e  opcode_i,
    input  logic                      rf_we_i,
    input  logic [REG_ADDR_W-1:0]     rf_waddr_i,
    input  logic [WORD_W-1:0]         src_a_i,
    input  logic [WORD_W-1:0]         src_b_i,

    output logic                      valid_m3_o,
    output logic                      valid_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_W-1:0]     rf_waddr_o,
    output logic [WORD_W-1:0]         rf_wdata_o
);

    // M1 outputs.
    logic                     m1_valid;
    logic                     m1_we;
    logic [REG_ADDR_W-1:0]    m1_waddr;
    m_ext_pkg::m_ext_opcode_e m1_opcode;
    logic [WORD_W-1:0]        m1_src_a;
    logic [WORD_W-1:0]        m1_src_b;
    logic                     m1_a_signed;
    logic                     m1_b_signed;
    logic                     m1_is_div;
    logic                     m1_is_rem;
    logic                     m1_high_sel;
    logic                     m1_div_zero;
    logic                     m1_div_ovf;

    // M4 outputs.
    logic                     m4_valid;
    logic                     m4_we;
    logic [REG_ADDR_W-1:0]    m4_waddr;
    m_ext_pkg::m_ext_opcode_e m4_opcode;
    logic [WORD_W-1:0]        m4_src_a;
    logic [WORD_W-1:0]        m4_src_b;
    logic                     m4_a_signed;
    logic                     m4_b_signed;
    logic                     m4_is_div;
    logic                     m4_is_rem;
    logic                     m4_high_sel;
    logic                     m4_div_zero;
    logic                     m4_div_ovf;

    m_ext_decode #(
        .WORD_W     (WORD_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) i_m_ext_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .opcode_i   (opcode_i),
        .rf_we_i    (rf_we_i),
        .rf_waddr_i (rf_waddr_i),
        .src_a_i    (src_a_i),
        .src_b_i    (src_b_i),
        .valid_o    (m1_valid),
        .rf_we_o    (m1_we),
        .rf_waddr_o (m1_waddr),
        .opcode_o   (m1_opcode),
        .src_a_o    (m1_src_a),
        .src_b_o    (m1_src_b),
        .a_signed_o (m1_a_signed),
        .b_signed_o (m1_b_signed),
        .is_div_o   (m1_is_div),
        .is_rem_o   (m1_is_rem),
        .high_sel_o (m1_high_sel),
        .div_zero_o (m1_div_zero),
        .div_ovf_o  (m1_div_ovf)
    );

    m_ext_delay #(
        .WORD_W     (WORD_W),
        .REG_ADDR_W (REG_ADDR_W),
        .DEPTH      (3) // M2 to M4.
    ) i_m_ext_delay (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (m1_valid),
        .rf_we_i     (m1_we),
        .rf_waddr_i  (m1_waddr),
        .opcode_i    (m1_opcode),
        .src_a_i     (m1_src_a),
        .src_b_i     (m1_src_b),
        .a_signed_i  (m1_a_signed),
        .b_signed_i  (m1_b_signed),
        .is_div_i    (m1_is_div),
        .is_rem_i    (m1_is_rem),
        .high_sel_i  (m1_high_sel),
        .div_zero_i  (m1_div_zero),
        .div_ovf_i   (m1_div_ovf),
        .valid_o     (m4_valid),
        .rf_we_o     (m4_we),
        .rf_waddr_o  (m4_waddr),
        .opcode_o    (m4_opcode),
        .src_a_o     (m4_src_a),
        .src_b_o     (m4_src_b),
        .a_signed_o  (m4_a_signed),
        .b_signed_o  (m4_b_signed),
        .is_div_o    (m4_is_div),
        .is_rem_o    (m4_is_rem),
        .high_sel_o  (m4_high_sel),
        .div_zero_o  (m4_div_zero),
        .div_ovf_o   (m4_div_ovf),
        .valid_tap_o (valid_m3_o)
    );

    m_ext_compute #(
        .WORD_W     (WORD_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) i_m_ext_compute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (m4_valid),
        .rf_we_i    (m4_we),
        .rf_waddr_i (m4_waddr),
        .opcode_i   (m4_opcode),
        .src_a_i    (m4_src_a),
        .src_b_i    (m4_src_b),
        .a_signed_i (m4_a_signed),
        .b_signed_i (m4_b_signed),
        .is_div_i   (m4_is_div),
        .is_rem_i   (m4_is_rem),
        .high_sel_i (m4_high_sel),
        .div_zero_i (m4_div_zero),
        .div_ovf_i  (m4_div_ovf),
        .valid_o    (valid_o),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o)
    );

endmodule

// ==== src/m_ext/m_ext_compute.sv ====
`timescale 1ns/1ps

module m_ext_compute #(
    parameter int WORD_W     = m_ext_pkg::WORD_W,
    parameter int REG_ADDR_W = m_ext_pkg::REG_ADDR_W
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      valid_i,
    input  logic                      rf_we_i,
    input  logic [REG_ADDR_W-1:0]     rf_waddr_i,
    input  m_ext_pkg::m_ext_opcode_e  opcode_i,
    input  logic [WORD_W-1:0]         src_a_i,
    input  logic [WORD_W-1:0]         src_b_i,
    input  logic                      a_signed_i,
    input  logic                      b_signed_i,
    input  logic                      is_div_i,
    input  logic                      is_rem_i,
    input  logic                      high_sel_i,
    input  logic                      div_zero_i,
    input  logic                      div_ovf_i,

    output logic                      valid_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_W-1:0]     rf_waddr_o,
    output logic [WORD_W-1:0]         rf_wdata_o
);

    logic                     valid_q;
    logic                     we_q;
    logic [REG_ADDR_W-1:0]    waddr_q;
    m_ext_pkg::m_ext_opcode_e opcode_q;
    logic [WORD_W-1:0]        a_q;
    logic [WORD_W-1:0]        b_q;
    logic                     a_signed_q;
    logic                     b_signed_q;
    logic                     is_div_q;
    logic                     is_rem_q;
    logic                     high_sel_q;
    logic                     div_zero_q;
    logic                     div_ovf_q;

    logic signed [WORD_W:0]     ext_a;
    logic signed [WORD_W:0]     ext_b;
    logic signed [2*WORD_W+1:0] prod;
    logic [WORD_W-1:0]          mul_word;

    logic              neg_a;
    logic              neg_b;
    logic [WORD_W-1:0] mag_a;
    logic [WORD_W-1:0] mag_b;
    logic [WORD_W-1:0] divisor;
    logic [WORD_W-1:0] quo_mag;
    logic [WORD_W-1:0] rem_mag;
    logic [WORD_W-1:0] quo;
    logic [WORD_W-1:0] rem;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= valid_i;
            we_q    <= rf_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        waddr_q    <= rf_waddr_i;
        opcode_q   <= opcode_i;
        a_q        <= src_a_i;
        b_q        <= src_b_i;
        a_signed_q <= a_signed_i;
        b_signed_q <= b_signed_i;
        is_div_q   <= is_div_i;
        is_rem_q   <= is_rem_i;
        high_sel_q <= high_sel_i;
        div_zero_q <= div_zero_i;
        div_ovf_q  <= div_ovf_i;
    end

    // one extra bit covers every signedness mix.
    assign ext_a    = {a_signed_q & a_q[WORD_W-1], a_q};
    assign ext_b    = {b_signed_q & b_q[WORD_W-1], b_q};
    assign prod     = ext_a * ext_b;
    assign mul_word = high_sel_q ? prod[2*WORD_W-1:WORD_W] : prod[WORD_W-1:0];

    assign neg_a = a_signed_q & a_q[WORD_W-1];
    assign neg_b = b_signed_q & b_q[WORD_W-1];
    assign mag_a = neg_a ? -a_q : a_q;
    assign mag_b = neg_b ? -b_q : b_q;

    // divider never sees zero.
    assign divisor = ((is_div_q | is_rem_q) & ~div_zero_q) ? mag_b
                   : {{(WORD_W-1){1'b0}}, 1'b1};
    assign quo_mag = mag_a / divisor;
    assign rem_mag = mag_a % divisor;

    always_comb begin
        if (div_zero_q) begin
            quo = '1;
            rem = a_q;
        end else if (div_ovf_q) begin
            quo = a_q;
            rem = '0;
        end else begin
            quo = (neg_a ^ neg_b) ? -quo_mag : quo_mag;
            rem = neg_a ? -rem_mag : rem_mag; // sign of the dividend.
        end

        case (opcode_q)
            m_ext_pkg::DIV, m_ext_pkg::DIVU: rf_wdata_o = quo;
            m_ext_pkg::REM, m_ext_pkg::REMU: rf_wdata_o = rem;
            default:                         rf_wdata_o = mul_word;
        endcase
    end

    assign valid_o    = valid_q;
    assign rf_we_o    = we_q;
    assign rf_waddr_o = waddr_q;

endmodule

// ==== src/m_ext/m_ext_delay.sv ====
`timescale 1ns/1ps

module m_ext_delay #(
    parameter int WORD_W     = m_ext_pkg::WORD_W,
    parameter int REG_ADDR_W = m_ext_pkg::REG_ADDR_W,
    parameter int DEPTH      = 3
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      valid_i,
    input  logic                      rf_we_i,
    input  logic [REG_ADDR_W-1:0]     rf_waddr_i,
    input  m_ext_pkg::m_ext_opcode_e  opcode_i,
    input  logic [WORD_W-1:0]         src_a_i,
    input  logic [WORD_W-1:0]         src_b_i,
    input  logic                      a_signed_i,
    input  logic                      b_signed_i,
    input  logic                      is_div_i,
    input  logic                      is_rem_i,
    input  logic                      high_sel_i,
    input  logic                      div_zero_i,
    input  logic                      div_ovf_i,

    output logic                      valid_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_W-1:0]     rf_waddr_o,
    output m_ext_pkg::m_ext_opcode_e  opcode_o,
    output logic [WORD_W-1:0]         src_a_o,
    output logic [WORD_W-1:0]         src_b_o,
    output logic                      a_signed_o,
    output logic                      b_signed_o,
    output logic                      is_div_o,
    output logic                      is_rem_o,
    output logic                      high_sel_o,
    output logic                      div_zero_o,
    output logic                      div_ovf_o,

    output logic                      valid_tap_o
);

    logic [DEPTH-1:0]         valid_q;
    logic [DEPTH-1:0]         we_q;
    logic [REG_ADDR_W-1:0]    waddr_q  [DEPTH];
    m_ext_pkg::m_ext_opcode_e opcode_q [DEPTH];
    logic [WORD_W-1:0]        src_a_q  [DEPTH];
    logic [WORD_W-1:0]        src_b_q  [DEPTH];
    logic [6:0]               flags_q  [DEPTH]; // decoded control bits.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            we_q    <= '0;
        end else begin
            valid_q <= {valid_q[DEPTH-2:0], valid_i};
            we_q    <= {we_q[DEPTH-2:0], rf_we_i};
        end
    end

    always_ff @(posedge clk_i) begin
        waddr_q[0]  <= rf_waddr_i;
        opcode_q[0] <= opcode_i;
        src_a_q[0]  <= src_a_i;
        src_b_q[0]  <= src_b_i;
        flags_q[0]  <= {a_signed_i, b_signed_i, is_div_i, is_rem_i,
                        high_sel_i, div_zero_i, div_ovf_i};
        for (int i = 1; i < DEPTH; i++) begin
            waddr_q[i]  <= waddr_q[i-1];
            opcode_q[i] <= opcode_q[i-1];
            src_a_q[i]  <= src_a_q[i-1];
            src_b_q[i]  <= src_b_q[i-1];
            flags_q[i]  <= flags_q[i-1];
        end
    end

    assign valid_o    = valid_q[DEPTH-1];
    assign rf_we_o    = we_q[DEPTH-1];
    assign rf_waddr_o = waddr_q[DEPTH-1];
    assign opcode_o   = opcode_q[DEPTH-1];
    assign src_a_o    = src_a_q[DEPTH-1];
    assign src_b_o    = src_b_q[DEPTH-1];
    assign {a_signed_o, b_signed_o, is_div_o, is_rem_o,
            high_sel_o, div_zero_o, div_ovf_o} = flags_q[DEPTH-1];

    // second register is stage M3.
    assign valid_tap_o = valid_q[1];

endmodule

// ==== src/m_ext/m_ext_decode.sv ====
`timescale 1ns/1ps

module m_ext_decode #(
    parameter int WORD_W     = m_ext_pkg::WORD_W,
    parameter int REG_ADDR_W = m_ext_pkg::REG_ADDR_W
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      valid_i,
    input  m_ext_pkg::m_ext_opcode_e  opcode_i,
    input  logic                      rf_we_i,
    input  logic [REG_ADDR_W-1:0]     rf_waddr_i,
    input  logic [WORD_W-1:0]         src_a_i,
    input  logic [WORD_W-1:0]         src_b_i,

    output logic                      valid_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_W-1:0]     rf_waddr_o,
    output m_ext_pkg::m_ext_opcode_e  opcode_o,
    output logic [WORD_W-1:0]         src_a_o,
    output logic [WORD_W-1:0]         src_b_o,
    output logic                      a_signed_o,
    output logic                      b_signed_o,
    output logic                      is_div_o,
    output logic                      is_rem_o,
    output logic                      high_sel_o,
    output logic                      div_zero_o,
    output logic                      div_ovf_o
);

    logic a_signed_d;
    logic b_signed_d;
    logic is_div_d;
    logic is_rem_d;
    logic high_sel_d;
    logic div_zero_d;
    logic div_ovf_d;

    always_comb begin
        a_signed_d = 1'b0;
        b_signed_d = 1'b0;
        is_div_d   = 1'b0;
        is_rem_d   = 1'b0;
        high_sel_d = 1'b0;
        case (opcode_i)
            m_ext_pkg::MUL: begin
                a_signed_d = 1'b1;
                b_signed_d = 1'b1;
            end
            m_ext_pkg::MULH: begin
                a_signed_d = 1'b1;
                b_signed_d = 1'b1;
                high_sel_d = 1'b1;
            end
            m_ext_pkg::MULHSU: begin
                a_signed_d = 1'b1;
                high_sel_d = 1'b1;
            end
            m_ext_pkg::MULHU: high_sel_d = 1'b1;
            m_ext_pkg::DIV: begin
                a_signed_d = 1'b1;
                b_signed_d = 1'b1;
                is_div_d   = 1'b1;
            end
            m_ext_pkg::DIVU: is_div_d = 1'b1;
            m_ext_pkg::REM: begin
                a_signed_d = 1'b1;
                b_signed_d = 1'b1;
                is_rem_d   = 1'b1;
            end
            m_ext_pkg::REMU: is_rem_d = 1'b1;
            default: ;
        endcase

        div_zero_d = (is_div_d | is_rem_d) & (src_b_i == '0);
        // most negative dividend over -1.
        div_ovf_d  = (is_div_d | is_rem_d) & a_signed_d & (&src_b_i)
                   & (src_a_i == {1'b1, {(WORD_W-1){1'b0}}});
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            rf_we_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            rf_we_o <= valid_i & rf_we_i; // no write without valid.
        end
    end

    always_ff @(posedge clk_i) begin
        rf_waddr_o <= rf_waddr_i;
        opcode_o   <= opcode_i;
        src_a_o    <= src_a_i;
        src_b_o    <= src_b_i;
        a_signed_o <= a_signed_d;
        b_signed_o <= b_signed_d;
        is_div_o   <= is_div_d;
        is_rem_o   <= is_rem_d;
        high_sel_o <= high_sel_d;
        div_zero_o <= div_zero_d;
        div_ovf_o  <= div_ovf_d;
    end

endmodule

// ==== common/m_ext_pkg.sv ====
package m_ext_pkg;

    // data path and register file widths.
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // edges from input sample to result on the outputs.
    localparam int M_EXT_LATENCY = 5;

    // encoded as the funct3 field of the OP opcode with funct7 = 0000001.
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } m_ext_opcode_e;

endpackage
